//--- logic/ic_pkg.sv
`default_nettype none

package ic_pkg;

  // ==========================================================================
  // message field widths
  // ==========================================================================

  localparam int ADDR_W = 4;
  localparam int DATA_W = 16;

  // crossbar control width is log2 of inputs times outputs for a 2x2 crossbar
  localparam int CTRL_W = $clog2(2 * 2);

  // ==========================================================================
  // message types
  // ==========================================================================

  typedef logic [DATA_W-1:0] data_t;

  // address-tagged message, used on the input and the tagged output
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    data_t             data;
  } msg_t;

  // router addresses, doubling as output tags
  typedef enum logic [ADDR_W-1:0] {
    // crossbar input 0 and tag of crossbar output 0
    PORT_INJECT_A = ADDR_W'(0),
    // crossbar control register
    PORT_XBAR_CFG = ADDR_W'(1),
    // crossbar input 1 and tag of crossbar output 1
    PORT_INJECT_B = ADDR_W'(2),
    // loopback through the fifo
    PORT_LOOPBACK = ADDR_W'(9)
  } port_e;

endpackage

`default_nettype wire

//--- logic/msg_router.sv
`default_nettype none

module msg_router (
  input  wire logic                        in_val_i,
  input  wire ic_pkg::msg_t                in_msg_i,
  output      logic                        in_rdy_o,

  // shared payload to all destinations
  output      ic_pkg::data_t               data_o,

  output      logic                        inj_a_val_o,
  input  wire logic                        inj_a_rdy_i,
  output      logic                        inj_b_val_o,
  input  wire logic                        inj_b_rdy_i,
  output      logic                        lb_val_o,
  input  wire logic                        lb_rdy_i,

  // crossbar configuration write
  output      logic                        cfg_we_o,
  output      logic [ic_pkg::CTRL_W-1:0]   cfg_ctrl_o
);

  assign data_o     = in_msg_i.data;
  assign cfg_ctrl_o = in_msg_i.data[ic_pkg::CTRL_W-1:0];

  // address decode raises at most one destination val
  always_comb begin
    inj_a_val_o = 1'b0;
    inj_b_val_o = 1'b0;
    lb_val_o    = 1'b0;
    cfg_we_o    = 1'b0;
    // config and unknown addresses are always taken
    in_rdy_o    = 1'b1;
    case (in_msg_i.addr)
      ic_pkg::PORT_INJECT_A: begin
        inj_a_val_o = in_val_i;
        in_rdy_o    = inj_a_rdy_i;
      end
      ic_pkg::PORT_INJECT_B: begin
        inj_b_val_o = in_val_i;
        in_rdy_o    = inj_b_rdy_i;
      end
      ic_pkg::PORT_LOOPBACK: begin
        lb_val_o = in_val_i;
        in_rdy_o = lb_rdy_i;
      end
      ic_pkg::PORT_XBAR_CFG: begin
        cfg_we_o = in_val_i;
      end
      default: begin
        // unused address is dropped
        in_rdy_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/blocking_xbar.sv
`default_nettype none

module blocking_xbar (
  input  wire logic                        clk,
  input  wire logic                        reset_i,

  input  wire logic                        cfg_we_i,
  input  wire logic [ic_pkg::CTRL_W-1:0]   cfg_ctrl_i,

  input  wire logic                        in0_val_i,
  input  wire ic_pkg::data_t               in0_data_i,
  output      logic                        in0_rdy_o,
  input  wire logic                        in1_val_i,
  input  wire ic_pkg::data_t               in1_data_i,
  output      logic                        in1_rdy_o,

  output      logic                        out0_val_o,
  output      ic_pkg::data_t               out0_data_o,
  input  wire logic                        out0_rdy_i,
  output      logic                        out1_val_o,
  output      ic_pkg::data_t               out1_data_o,
  input  wire logic                        out1_rdy_i
);

  logic [ic_pkg::CTRL_W-1:0] ctrl_q;
  logic                      sel_in;
  logic                      sel_out;
  logic                      path_val;
  logic                      path_rdy;
  ic_pkg::data_t             path_data;

  // ==========================================================================
  // control register
  // ==========================================================================

  // resets to input 0 driving output 0
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ctrl_q <= '0;
    end else if (cfg_we_i) begin
      ctrl_q <= cfg_ctrl_i;
    end
  end

  // upper bit picks input, lower bit picks output
  assign sel_in  = ctrl_q[1];
  assign sel_out = ctrl_q[0];

  // ==========================================================================
  // single open path
  // ==========================================================================

  assign path_val  = sel_in ? in1_val_i  : in0_val_i;
  assign path_data = sel_in ? in1_data_i : in0_data_i;
  assign path_rdy  = sel_out ? out1_rdy_i : out0_rdy_i;

  // blocked input never sees rdy
  assign in0_rdy_o = !sel_in && path_rdy;
  assign in1_rdy_o = sel_in && path_rdy;

  // blocked output never shows val
  assign out0_val_o  = !sel_out && path_val;
  assign out1_val_o  = sel_out && path_val;
  assign out0_data_o = path_data;
  assign out1_data_o = path_data;

endmodule

`default_nettype wire

//--- logic/msg_fifo.sv
`default_nettype none

module msg_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic          clk,
  input  wire logic          reset_i,

  input  wire logic          in_val_i,
  input  wire ic_pkg::data_t in_data_i,
  output      logic          in_rdy_o,

  output      logic          out_val_o,
  output      ic_pkg::data_t out_data_o,
  input  wire logic          out_rdy_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  ic_pkg::data_t    mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             enq;
  logic             deq;

  assign full = (count == CNT_W'(FIFO_DEPTH));

  // a full fifo still takes data when the head leaves this cycle
  assign in_rdy_o   = !full || out_rdy_i;
  assign out_val_o  = (count != '0);
  assign out_data_o = mem[rd_ptr];

  assign enq = in_val_i && in_rdy_o;
  assign deq = out_val_o && out_rdy_i;

  // storage
  always_ff @(posedge clk) begin
    if (enq) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  // pointers wrap on their own with a power of two depth
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (deq) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({enq, deq})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/prio_arbiter.sv
`default_nettype none

module prio_arbiter (
  // crossbar output 0 has the highest priority
  input  wire logic          req0_val_i,
  input  wire ic_pkg::data_t req0_data_i,
  output      logic          req0_rdy_o,
  // crossbar output 1
  input  wire logic          req1_val_i,
  input  wire ic_pkg::data_t req1_data_i,
  output      logic          req1_rdy_o,
  // loopback fifo has the lowest priority
  input  wire logic          req2_val_i,
  input  wire ic_pkg::data_t req2_data_i,
  output      logic          req2_rdy_o,

  output      logic          out_val_o,
  output      ic_pkg::msg_t  out_msg_o,
  input  wire logic          out_rdy_i
);

  logic [2:0] grant;

  // fixed priority where the lowest index wins
  always_comb begin
    grant = 3'b000;
    if (req0_val_i) begin
      grant = 3'b001;
    end else if (req1_val_i) begin
      grant = 3'b010;
    end else if (req2_val_i) begin
      grant = 3'b100;
    end
  end

  assign req0_rdy_o = grant[0] && out_rdy_i;
  assign req1_rdy_o = grant[1] && out_rdy_i;
  assign req2_rdy_o = grant[2] && out_rdy_i;

  assign out_val_o = |grant;

  // tag each message with the port it came from
  always_comb begin
    out_msg_o.addr = ic_pkg::PORT_LOOPBACK;
    out_msg_o.data = req2_data_i;
    if (grant[0]) begin
      out_msg_o.addr = ic_pkg::PORT_INJECT_A;
      out_msg_o.data = req0_data_i;
    end else if (grant[1]) begin
      out_msg_o.addr = ic_pkg::PORT_INJECT_B;
      out_msg_o.data = req1_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/interconnect_top.sv
`default_nettype none

module interconnect_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic         clk,
  input  wire logic         reset_i,

  input  wire logic         in_val_i,
  input  wire ic_pkg::msg_t in_msg_i,
  output      logic         in_rdy_o,

  output      logic         out_val_o,
  output      ic_pkg::msg_t out_msg_o,
  input  wire logic         out_rdy_i
);

  // ==========================================================================
  // router to destinations
  // ==========================================================================

  ic_pkg::data_t             rt_data;
  logic                      inj_a_val;
  logic                      inj_a_rdy;
  logic                      inj_b_val;
  logic                      inj_b_rdy;
  logic                      lb_val;
  logic                      lb_rdy;
  logic                      cfg_we;
  logic [ic_pkg::CTRL_W-1:0] cfg_ctrl;

  // ==========================================================================
  // sources into the arbiter
  // ==========================================================================

  logic          x0_val;
  ic_pkg::data_t x0_data;
  logic          x0_rdy;
  logic          x1_val;
  ic_pkg::data_t x1_data;
  logic          x1_rdy;
  logic          fifo_val;
  ic_pkg::data_t fifo_data;
  logic          fifo_rdy;

  msg_router router (
    .in_val_i    (in_val_i),
    .in_msg_i    (in_msg_i),
    .in_rdy_o    (in_rdy_o),
    .data_o      (rt_data),
    .inj_a_val_o (inj_a_val),
    .inj_a_rdy_i (inj_a_rdy),
    .inj_b_val_o (inj_b_val),
    .inj_b_rdy_i (inj_b_rdy),
    .lb_val_o    (lb_val),
    .lb_rdy_i    (lb_rdy),
    .cfg_we_o    (cfg_we),
    .cfg_ctrl_o  (cfg_ctrl)
  );

  // inject a on input 0, inject b on input 1
  blocking_xbar xbar (
    .clk         (clk),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we),
    .cfg_ctrl_i  (cfg_ctrl),
    .in0_val_i   (inj_a_val),
    .in0_data_i  (rt_data),
    .in0_rdy_o   (inj_a_rdy),
    .in1_val_i   (inj_b_val),
    .in1_data_i  (rt_data),
    .in1_rdy_o   (inj_b_rdy),
    .out0_val_o  (x0_val),
    .out0_data_o (x0_data),
    .out0_rdy_i  (x0_rdy),
    .out1_val_o  (x1_val),
    .out1_data_o (x1_data),
    .out1_rdy_i  (x1_rdy)
  );

  // loopback buffer
  msg_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) lb_fifo (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_val_i   (lb_val),
    .in_data_i  (rt_data),
    .in_rdy_o   (lb_rdy),
    .out_val_o  (fifo_val),
    .out_data_o (fifo_data),
    .out_rdy_i  (fifo_rdy)
  );

  prio_arbiter arbiter (
    .req0_val_i  (x0_val),
    .req0_data_i (x0_data),
    .req0_rdy_o  (x0_rdy),
    .req1_val_i  (x1_val),
    .req1_data_i (x1_data),
    .req1_rdy_o  (x1_rdy),
    .req2_val_i  (fifo_val),
    .req2_data_i (fifo_data),
    .req2_rdy_o  (fifo_rdy),
    .out_val_o   (out_val_o),
    .out_msg_o   (out_msg_o),
    .out_rdy_i   (out_rdy_i)
  );

endmodule

`default_nettype wire

//--- sim/interconnect_props.sv
`default_nettype none

module interconnect_props (
  input wire logic         clk,
  input wire logic         reset_i,
  input wire logic         out_val_i,
  input wire ic_pkg::msg_t out_msg_i,
  input wire logic         out_rdy_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // output idle while reset is held
  assert property (@(posedge clk) reset_i && $past(reset_i) |-> !out_val_i)
    else $error("output valid during reset");

  // a stalled output keeps its message
  assert property (@(posedge clk) disable iff (reset_i)
    out_val_i && !out_rdy_i |=> out_val_i && $stable(out_msg_i))
    else $error("output changed while stalled");

  // only the three arbiter sources can appear as tags
  assert property (@(posedge clk) disable iff (reset_i)
    out_val_i |-> (out_msg_i.addr == ic_pkg::PORT_INJECT_A ||
                   out_msg_i.addr == ic_pkg::PORT_INJECT_B ||
                   out_msg_i.addr == ic_pkg::PORT_LOOPBACK))
    else $error("output tag outside 0, 2 and 9");

endmodule

bind interconnect_top interconnect_props props (
  .clk       (clk),
  .reset_i   (reset_i),
  .out_val_i (out_val_o),
  .out_msg_i (out_msg_o),
  .out_rdy_i (out_rdy_i)
);

`default_nettype wire

//--- sim/interconnect_tb.sv
`default_nettype none

module interconnect_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIFO_DEPTH   = 4;
  localparam int BLOCK_CYCLES = 4;

  // one table row of stimulus, expected result and output stall mode
  typedef struct packed {
    ic_pkg::msg_t              msg;
    logic                      expects;
    logic [ic_pkg::ADDR_W-1:0] tag;
    logic                      hold;
    logic                      block;
  } entry_t;

  logic         clk = 1'b0;
  logic         reset_i;
  logic         in_val_i;
  ic_pkg::msg_t in_msg_i;
  logic         in_rdy_o;
  logic         out_val_o;
  ic_pkg::msg_t out_msg_o;
  logic         out_rdy_i;

  entry_t       table_q[$];
  string        name_q[$];
  ic_pkg::msg_t exp_msg_q[$];
  string        exp_name_q[$];
  int           exp_cycle_q[$];
  ic_pkg::msg_t act_msg_q[$];
  int           act_cycle_q[$];
  logic [31:0]  lcg_state = 32'hb7e9;
  int           cycle = 0;
  int           limit_cycles = 0;

  interconnect_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk       (clk),
    .reset_i   (reset_i),
    .in_val_i  (in_val_i),
    .in_msg_i  (in_msg_i),
    .in_rdy_o  (in_rdy_o),
    .out_val_o (out_val_o),
    .out_msg_o (out_msg_o),
    .out_rdy_i (out_rdy_i)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // every completed output transfer and its cycle
  always @(posedge clk) begin
    if (!reset_i && out_val_o && out_rdy_i) begin
      act_msg_q.push_back(out_msg_o);
      act_cycle_q.push_back(cycle);
    end
  end

  function automatic ic_pkg::data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic add_entry(input string name, input logic [3:0] addr,
                           input ic_pkg::data_t data, input logic expects,
                           input logic [3:0] tag, input logic hold, input logic block);
    entry_t e;
    e.msg.addr = addr;
    e.msg.data = data;
    e.expects  = expects;
    e.tag      = tag;
    e.hold     = hold;
    e.block    = block;
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  task automatic build_table();
    add_entry("inject_a_reset", ic_pkg::PORT_INJECT_A, next_rand(), 1'b1,
              ic_pkg::PORT_INJECT_A, 1'b0, 1'b0);
    // input 0 to output 1
    add_entry("cfg_a_to_out1", ic_pkg::PORT_XBAR_CFG, 16'h0001, 1'b0, 4'd0, 1'b0, 1'b0);
    add_entry("inject_a_out1", ic_pkg::PORT_INJECT_A, next_rand(), 1'b1,
              ic_pkg::PORT_INJECT_B, 1'b0, 1'b0);
    // input 1 to output 0
    add_entry("cfg_b_to_out0", ic_pkg::PORT_XBAR_CFG, 16'h0002, 1'b0, 4'd0, 1'b0, 1'b0);
    add_entry("inject_b_out0", ic_pkg::PORT_INJECT_B, next_rand(), 1'b1,
              ic_pkg::PORT_INJECT_A, 1'b0, 1'b0);
    add_entry("cfg_restore", ic_pkg::PORT_XBAR_CFG, 16'h0000, 1'b0, 4'd0, 1'b0, 1'b0);
    add_entry("inject_a_again", ic_pkg::PORT_INJECT_A, next_rand(), 1'b1,
              ic_pkg::PORT_INJECT_A, 1'b0, 1'b0);
    add_entry("loopback_single", ic_pkg::PORT_LOOPBACK, next_rand(), 1'b1,
              ic_pkg::PORT_LOOPBACK, 1'b0, 1'b0);
    // fill the loopback FIFO behind a stalled output
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      add_entry($sformatf("loopback_fill_%0d", k), ic_pkg::PORT_LOOPBACK, next_rand(), 1'b1,
                ic_pkg::PORT_LOOPBACK, 1'b1, 1'b0);
    end
    add_entry("loopback_blocked", ic_pkg::PORT_LOOPBACK, next_rand(), 1'b1,
              ic_pkg::PORT_LOOPBACK, 1'b0, 1'b1);
    add_entry("unused_5", 4'd5, next_rand(), 1'b0, 4'd0, 1'b0, 1'b0);
    add_entry("unused_15", 4'd15, next_rand(), 1'b0, 4'd0, 1'b0, 1'b0);
    add_entry("loopback_after_unused", ic_pkg::PORT_LOOPBACK, next_rand(), 1'b1,
              ic_pkg::PORT_LOOPBACK, 1'b0, 1'b0);
  endtask

  task wait_idle();
    do begin
      @(posedge clk);
    end while (out_val_o);
  endtask

  task apply_entry(input int idx);
    entry_t       e;
    ic_pkg::msg_t m;
    e = table_q[idx];
    // a hold run starts with the output drained
    if (e.hold && out_rdy_i) begin
      in_val_i <= 1'b0;
      wait_idle();
    end
    in_val_i  <= 1'b1;
    in_msg_i  <= e.msg;
    out_rdy_i <= !(e.hold || e.block);
    if (e.block) begin
      repeat (BLOCK_CYCLES) begin
        @(posedge clk);
        assert (!in_rdy_o)
          else abort_run($sformatf("%s was accepted with the FIFO full", name_q[idx]));
      end
      out_rdy_i <= 1'b1;
    end
    do begin
      @(posedge clk);
    end while (!in_rdy_o);
    if (e.expects) begin
      m.addr = e.tag;
      m.data = e.msg.data;
      exp_msg_q.push_back(m);
      exp_name_q.push_back(name_q[idx]);
      exp_cycle_q.push_back(cycle);
    end
  endtask

  // watchdog scaled to the table length
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    abort_run("watchdog expired, the DUT stopped moving messages");
  end

  initial begin
    reset_i   = 1'b1;
    in_val_i  = 1'b0;
    in_msg_i  = '0;
    out_rdy_i = 1'b1;
    build_table();
    limit_cycles = (table_q.size() + 20) * 20;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    for (int i = 0; i < table_q.size(); i++) begin
      apply_entry(i);
    end
    in_val_i  <= 1'b0;
    out_rdy_i <= 1'b1;
    wait_idle();

    // ========================================================================
    // in-order comparison
    // ========================================================================
    for (int i = 0; i < exp_msg_q.size(); i++) begin
      assert (i < act_msg_q.size())
        else abort_run($sformatf("no output seen for %s", exp_name_q[i]));
      assert (act_msg_q[i].addr == exp_msg_q[i].addr)
        else abort_run($sformatf("[FAIL] %s tag expected %0h actual %0h", exp_name_q[i],
                                 exp_msg_q[i].addr, act_msg_q[i].addr));
      assert (act_msg_q[i].data == exp_msg_q[i].data)
        else abort_run($sformatf("[FAIL] %s data expected %h actual %h", exp_name_q[i],
                                 exp_msg_q[i].data, act_msg_q[i].data));
      // loopback goes through the FIFO, inject passes straight through
      if (exp_msg_q[i].addr == ic_pkg::PORT_LOOPBACK) begin
        assert (act_cycle_q[i] > exp_cycle_q[i])
          else abort_run($sformatf("[FAIL] %s cycle expected > %0d actual %0d",
                                   exp_name_q[i], exp_cycle_q[i], act_cycle_q[i]));
      end else begin
        assert (act_cycle_q[i] == exp_cycle_q[i])
          else abort_run($sformatf("[FAIL] %s cycle expected %0d actual %0d",
                                   exp_name_q[i], exp_cycle_q[i], act_cycle_q[i]));
      end
    end
    assert (act_msg_q.size() == exp_msg_q.size())
      else abort_run("an output appeared for a message that should have been dropped");

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/ic_pkg.sv
logic/msg_router.sv
logic/blocking_xbar.sv
logic/msg_fifo.sv
logic/prio_arbiter.sv
logic/interconnect_top.sv
sim/interconnect_props.sv
sim/interconnect_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= interconnect_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
